//--- verilog/unwrap_settings.svh
`ifndef UNWRAP_SETTINGS_SVH
`define UNWRAP_SETTINGS_SVH

// sizes shared by the unwrap controller

// entries in the cipher word FIFO, power of two
`define FIFO_DEPTH 4

// longest passphrase in bytes, entry closes here
`define PASS_MAX 8

// exponent bits scanned per word
`define EXP_BITS 32

`endif

//--- verilog/unwrap_pkg.sv
`default_nettype none

`include "unwrap_settings.svh"

package unwrap_pkg;

	// one bus word on every stream
	typedef logic [31:0] word_t;

	// passphrase check value, matches header upper half
	typedef logic [15:0] tag_t;

	// FIFO occupancy, one bit over the address width
	typedef logic [$clog2(`FIFO_DEPTH):0] fill_t;

	// next check value from the running one and a typed byte
	function automatic tag_t pass_fold(
		input tag_t acc,
		input logic [7:0] kb_byte
	);
		tag_t rot;
		rot = {acc[12:0], acc[15:13]}; // rotate left by 3
		return rot ^ {8'h00, kb_byte}; // byte zero extended
	endfunction

endpackage

`default_nettype wire

//--- verilog/cipher_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "unwrap_settings.svh"

module cipher_fifo (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic push_i,
	input  wire unwrap_pkg::word_t push_data_i,
	input  wire logic pop_i,
	output unwrap_pkg::word_t pop_data_o,
	output logic full_o,
	output logic empty_o
);
	import unwrap_pkg::*;

	localparam int AW = $clog2(`FIFO_DEPTH); // address width

	word_t mem [`FIFO_DEPTH]; // encrypted words waiting
	logic [AW-1:0] wr_ptr; // next free slot
	logic [AW-1:0] rd_ptr; // head slot
	fill_t fill; // entries held

	// storage, written on push only
	always_ff @(posedge clk) begin
		if (push_i)
			mem[wr_ptr] <= push_data_i;
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_i, pop_i})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill; // both or neither
			endcase
		end
	end

	assign pop_data_o = mem[rd_ptr]; // head visible before pop
	assign full_o = (fill == fill_t'(`FIFO_DEPTH));
	assign empty_o = (fill == '0);

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push_i && full_o));
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop_i && empty_o));

endmodule

`default_nettype wire

//--- verilog/key_intake.sv
`timescale 1ns/1ps
`default_nettype none

`include "unwrap_settings.svh"

module key_intake (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic stall_i,
	input  wire unwrap_pkg::word_t rsa_data_i,
	input  wire logic rsa_valid_i,
	output logic rsa_ready_o,
	input  wire logic [7:0] ps2_data_i,
	input  wire logic ps2_valid_i,
	input  wire logic ps2_done_i,
	input  wire logic ps2_reset_i,
	input  wire unwrap_pkg::word_t aes_data_i,
	input  wire logic aes_valid_i,
	output logic aes_ready_o,
	output logic led_pass_o,
	output logic led_fail_o,
	input  wire logic fifo_full_i,
	output logic push_o,
	output unwrap_pkg::word_t push_data_o,
	output unwrap_pkg::word_t exp_o,
	output unwrap_pkg::word_t mod_o
);
	import unwrap_pkg::*;

	localparam int PCW = $clog2(`PASS_MAX + 1); // passphrase count width

	typedef enum logic [1:0] {
		S_LOAD,    // key block words
		S_PASS,    // keyboard entry
		S_JUDGE,   // compare fold with tag
		S_SESSION  // session words to FIFO
	} state_t;

	state_t state;
	logic [1:0] kcnt; // key word index
	logic [PCW-1:0] pcnt; // bytes folded so far
	tag_t tag; // from header upper half
	tag_t acc; // running fold
	logic rsa_take; // key word handshake
	logic kb_take; // keyboard byte accepted
	logic pass_full; // this byte hits PASS_MAX

	assign rsa_take = rsa_valid_i && rsa_ready_o && !stall_i;
	assign kb_take = (state == S_PASS) && ps2_valid_i && !stall_i;
	assign pass_full = (pcnt + 1'b1) == PCW'(`PASS_MAX);

	// session side is plain handshake into the FIFO
	assign aes_ready_o = (state == S_SESSION) && !fifo_full_i;
	assign push_o = aes_valid_i && aes_ready_o && !stall_i;
	assign push_data_o = aes_data_i; // encrypted word goes in untouched

	// control state
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_LOAD;
			kcnt <= '0;
			pcnt <= '0;
			acc <= '0;
			rsa_ready_o <= 1'b1; // ready from reset on
			led_pass_o <= 1'b0;
			led_fail_o <= 1'b0;
		end else if (!stall_i) begin
			case (state)
				S_LOAD: begin
					if (rsa_take) begin
						kcnt <= kcnt + 2'd1;
						if (kcnt == 2'd2) begin // modulus is the last word
							rsa_ready_o <= 1'b0; // never again
							state <= S_PASS;
						end
					end
				end
				S_PASS: begin
					if (kb_take) begin
						led_fail_o <= 1'b0; // any byte clears the old verdict
						if (ps2_reset_i) begin
							acc <= '0; // drop partial entry
							pcnt <= '0;
						end else if (ps2_done_i) begin
							state <= S_JUDGE; // enter key not folded
						end else begin
							acc <= pass_fold(acc, ps2_data_i);
							pcnt <= pcnt + 1'b1;
							if (pass_full)
								state <= S_JUDGE;
						end
					end
				end
				S_JUDGE: begin
					if (acc == tag) begin
						led_pass_o <= 1'b1; // sticky
						state <= S_SESSION;
					end else begin
						led_fail_o <= 1'b1;
						acc <= '0; // fresh entry next
						pcnt <= '0;
						state <= S_PASS;
					end
				end
				default: begin
					state <= S_SESSION; // stays here until reset
				end
			endcase
		end
	end

	// key block payload
	always_ff @(posedge clk) begin
		if (rsa_take) begin
			case (kcnt)
				2'd0: tag <= rsa_data_i[31:16]; // tag in upper half
				2'd1: exp_o <= rsa_data_i;
				default: mod_o <= rsa_data_i;
			endcase
		end
	end

	// key stream stays closed once the block is in
	a_key_closed: assert property (@(posedge clk) disable iff (rst)
		(state != S_LOAD) |-> !rsa_ready_o);

	// verdict LEDs are exclusive
	a_led_excl: assert property (@(posedge clk) disable iff (rst)
		!(led_pass_o && led_fail_o));

endmodule

`default_nettype wire

//--- verilog/modexp_unwrap.sv
`timescale 1ns/1ps
`default_nettype none

`include "unwrap_settings.svh"

module modexp_unwrap (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic stall_i,
	input  wire unwrap_pkg::word_t exp_i,
	input  wire unwrap_pkg::word_t mod_i,
	input  wire logic empty_i,
	input  wire unwrap_pkg::word_t head_i,
	output logic pop_o,
	output unwrap_pkg::word_t out_data_o,
	output logic out_valid_o,
	input  wire logic out_ready_i
);
	import unwrap_pkg::*;

	localparam int BW = $clog2(`EXP_BITS); // step counter width

	logic busy; // exponent scan running
	logic [BW-1:0] bcnt; // step index
	logic last_step; // final exponent bit this cycle
	word_t base; // running square of the cipher word
	word_t result; // running product
	word_t exp_sh; // exponent, lsb first
	logic [63:0] mul_full; // result * base
	logic [63:0] sq_full; // base * base
	logic [63:0] mul_red;
	logic [63:0] sq_red;
	word_t res_next;

	// take a new word only with nothing in flight or held
	assign pop_o = !busy && !out_valid_o && !empty_i && !stall_i;
	assign last_step = (bcnt == BW'(`EXP_BITS - 1));

	// one square-and-multiply step
	assign mul_full = {32'd0, result} * {32'd0, base};
	assign sq_full = {32'd0, base} * {32'd0, base};
	assign mul_red = mul_full % {32'd0, mod_i};
	assign sq_red = sq_full % {32'd0, mod_i};
	assign res_next = exp_sh[0] ? mul_red[31:0] : result; // multiply on set bit

	// control
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			bcnt <= '0;
			out_valid_o <= 1'b0;
		end else if (!stall_i) begin
			if (pop_o) begin
				busy <= 1'b1;
				bcnt <= '0;
			end else if (busy) begin
				bcnt <= bcnt + 1'b1;
				if (last_step) begin
					busy <= 1'b0;
					out_valid_o <= 1'b1; // result lands with data
				end
			end else if (out_valid_o && out_ready_i) begin
				out_valid_o <= 1'b0; // consumer took it
			end
		end
	end

	// datapath, frozen by stall like the control
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			if (pop_o) begin
				base <= head_i % mod_i; // reduce cipher word first
				result <= (mod_i == 32'd1) ? 32'd0 : 32'd1; // x^0 mod m
				exp_sh <= exp_i;
			end else if (busy) begin
				result <= res_next;
				base <= sq_red[31:0];
				exp_sh <= exp_sh >> 1;
				if (last_step)
					out_data_o <= res_next; // holds until accepted
			end
		end
	end

	// key block must be loaded before any session word is unwrapped
	a_mod_set: assert property (@(posedge clk) disable iff (rst) pop_o |-> (mod_i != '0));

endmodule

`default_nettype wire

//--- verilog/key_unwrap_top.sv
`timescale 1ns/1ps
`default_nettype none

module key_unwrap_top (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic stall_i,
	input  wire unwrap_pkg::word_t rsa_data_i,
	input  wire logic rsa_valid_i,
	output logic rsa_ready_o,
	input  wire logic [7:0] ps2_data_i,
	input  wire logic ps2_valid_i,
	input  wire logic ps2_done_i,
	input  wire logic ps2_reset_i,
	input  wire unwrap_pkg::word_t aes_data_i,
	input  wire logic aes_valid_i,
	output logic aes_ready_o,
	output logic led_pass_o,
	output logic led_fail_o,
	output unwrap_pkg::word_t out_data_o,
	output logic out_valid_o,
	input  wire logic out_ready_i
);
	import unwrap_pkg::*;

	logic push; // intake to FIFO
	word_t push_data;
	logic pop; // unwrap engine from FIFO
	word_t head; // FIFO head word
	logic full;
	logic empty;
	word_t exp_w; // key block exponent
	word_t mod_w; // key block modulus

	// producer, key block, passphrase and session words
	key_intake u_intake (
		.clk(clk), .rst(rst), .stall_i(stall_i),
		.rsa_data_i(rsa_data_i), .rsa_valid_i(rsa_valid_i), .rsa_ready_o(rsa_ready_o),
		.ps2_data_i(ps2_data_i), .ps2_valid_i(ps2_valid_i),
		.ps2_done_i(ps2_done_i), .ps2_reset_i(ps2_reset_i),
		.aes_data_i(aes_data_i), .aes_valid_i(aes_valid_i), .aes_ready_o(aes_ready_o),
		.led_pass_o(led_pass_o), .led_fail_o(led_fail_o),
		.fifo_full_i(full), .push_o(push), .push_data_o(push_data),
		.exp_o(exp_w), .mod_o(mod_w)
	);

	cipher_fifo u_fifo (
		.clk(clk), .rst(rst),
		.push_i(push), .push_data_i(push_data), .pop_i(pop),
		.pop_data_o(head), .full_o(full), .empty_o(empty)
	);

	// consumer, modexp and output register
	modexp_unwrap u_modexp (
		.clk(clk), .rst(rst), .stall_i(stall_i),
		.exp_i(exp_w), .mod_i(mod_w), .empty_i(empty), .head_i(head),
		.pop_o(pop), .out_data_o(out_data_o), .out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i)
	);

endmodule

`default_nettype wire

//--- dv/key_unwrap_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "unwrap_settings.svh"

module key_unwrap_tb;
	logic clk = 1'b0;
	logic rst = 1'b1;
	logic stall_i, rsa_valid_i, ps2_valid_i, ps2_done_i, ps2_reset_i, aes_valid_i;
	logic out_ready_i;
	logic [31:0] rsa_data_i, aes_data_i, out_data_o;
	logic [7:0] ps2_data_i;
	logic rsa_ready_o, aes_ready_o, led_pass_o, led_fail_o, out_valid_o;
	int seed = 32'h5d6c; // shared random stream
	int errors = 0;
	int timeouts = 0;
	int kt; // key words taken
	int n_in; // session words taken
	int n_out; // results consumed
	int tb_cnt; // bytes in current entry
	logic [15:0] tb_acc; // reference fold
	logic [15:0] tag_m; // tag sent in the header
	logic [31:0] exp_m, mod_m;
	logic judging; // DUT compare cycle
	logic verdict_ok; // expected outcome of that compare
	logic rnd_on = 1'b0; // random stall and back-pressure
	logic [31:0] exp_q [$]; // expected results, arrival order
	logic [7:0] pw_good [`PASS_MAX] = '{8'h6b, 8'h65, 8'h79, 8'h21, 8'h00, 8'h00, 8'h00, 8'h00};
	logic [7:0] pw_bad [`PASS_MAX] = '{8'h79, 8'h21, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
	logic [7:0] pw_long [`PASS_MAX] = '{8'h70, 8'h61, 8'h73, 8'h73, 8'h77, 8'h6f, 8'h72, 8'h64};
	wire in_entry = (kt == 3) && !judging && !led_pass_o; // DUT listens to keyboard
	wire kb_take = in_entry && ps2_valid_i && !stall_i;
	wire end_evt = kb_take && !ps2_reset_i && (ps2_done_i || tb_cnt == `PASS_MAX - 1);

	key_unwrap_top dut (.*);

	always #20 clk = ~clk;

	function automatic logic [15:0] fold_byte(input logic [15:0] a, input logic [7:0] b);
		return {a[12:0], a[15:13]} ^ {8'h00, b}; // rotl 3, xor byte
	endfunction

	function automatic logic [15:0] tag_of(input logic [7:0] pw [`PASS_MAX], input int n);
		logic [15:0] a;
		a = '0;
		for (int i = 0; i < n; i++)
			a = fold_byte(a, pw[i]);
		return a;
	endfunction

	// msb first, unlike the DUT scan
	function automatic logic [31:0] mod_pow(input logic [31:0] c, e, m);
		logic [63:0] r;
		r = 64'd1 % m;
		for (int i = `EXP_BITS - 1; i >= 0; i--) begin
			r = (r * r) % m;
			if (e[i])
				r = (r * (c % m)) % m;
		end
		return r[31:0];
	endfunction

	task automatic report_mismatch(input string what);
		errors++;
		$display("MISMATCH at %0t: %s", $time, what);
	endtask

	task automatic time_out(input string what);
		timeouts++;
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("mismatches: %0d  timeouts: %0d", errors, timeouts);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		repeat (5) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic load_key(input logic [31:0] hdr, input logic [31:0] e, input logic [31:0] m);
		logic [31:0] w [3];
		int t;
		w = '{hdr, e, m};
		tag_m = hdr[31:16];
		exp_m = e;
		mod_m = m;
		for (int i = 0; i < 3; i++) begin
			rsa_data_i = w[i];
			rsa_valid_i = 1'b1;
			t = 0;
			while (kt == i && t < 50) begin
				@(negedge clk);
				t++;
			end
			if (kt == i)
				time_out("key word handshake");
		end
		rsa_valid_i = 1'b0;
	endtask

	task automatic type_byte(input logic [7:0] b, input logic done, input logic clr);
		ps2_data_i = b;
		ps2_done_i = done;
		ps2_reset_i = clr;
		ps2_valid_i = 1'b1;
		@(negedge clk);
		ps2_valid_i = 1'b0;
		ps2_done_i = 1'b0;
		ps2_reset_i = 1'b0;
	endtask

	task automatic type_entry(input logic [7:0] pw [`PASS_MAX], input int n, input logic done);
		for (int i = 0; i < n; i++)
			type_byte(pw[i], 1'b0, 1'b0);
		if (done)
			type_byte(8'h0d, 1'b1, 1'b0); // enter key, not folded
	endtask

	task automatic wait_verdict(input string what);
		int t;
		t = 0;
		while (!led_pass_o && !led_fail_o && t < 20) begin
			@(negedge clk);
			t++;
		end
		if (!led_pass_o && !led_fail_o)
			time_out(what);
	endtask

	task automatic send_session(input int count);
		logic [31:0] words [$];
		int t;
		for (int k = 0; k < count; k++)
			words.push_back($unsigned($random(seed)) % mod_m); // below modulus
		aes_valid_i = 1'b1;
		for (int k = 0; k < count; k++) begin
			aes_data_i = words[k];
			t = 0;
			while (n_in == k && t < 2000) begin
				@(negedge clk);
				t++;
			end
			if (n_in == k)
				time_out("session word handshake");
		end
		aes_valid_i = 1'b0;
	endtask

	// reference model, follows the handshakes as the DUT sees them
	always @(posedge clk) begin
		if (rst) begin
			kt <= 0;
			n_in <= 0;
			n_out <= 0;
			judging <= 1'b0;
			tb_acc <= '0;
			tb_cnt <= 0;
			exp_q.delete();
		end else begin
			judging <= end_evt;
			if (rsa_valid_i && rsa_ready_o && !stall_i)
				kt <= kt + 1;
			if (end_evt) begin
				verdict_ok <= ((ps2_done_i ? tb_acc : fold_byte(tb_acc, ps2_data_i)) == tag_m);
				tb_acc <= '0;
				tb_cnt <= 0;
			end else if (kb_take) begin
				tb_acc <= ps2_reset_i ? 16'h0000 : fold_byte(tb_acc, ps2_data_i);
				tb_cnt <= ps2_reset_i ? 0 : tb_cnt + 1;
			end
			if (aes_valid_i && aes_ready_o && !stall_i) begin
				exp_q.push_back(mod_pow(aes_data_i, exp_m, mod_m));
				n_in <= n_in + 1;
			end
			if (out_valid_o && out_ready_i && !stall_i) begin
				n_out <= n_out + 1;
				a_data: assert (exp_q.size() != 0 && out_data_o == exp_q[0])
					else report_mismatch($sformatf("out_data_o %h, expected %h",
						out_data_o, exp_q[0]));
				if (exp_q.size() != 0)
					void'(exp_q.pop_front());
			end
		end
	end

	// random stall and output back-pressure in the session phase
	always @(negedge clk) begin
		if (rnd_on) begin
			stall_i = (($random(seed) & 3) == 0);
			out_ready_i = $random(seed) & 1;
		end
	end

	a_reset_idle: assert property (@(posedge clk) $fell(rst) |->
		rsa_ready_o && !aes_ready_o && !led_pass_o && !led_fail_o && !out_valid_o)
		else report_mismatch("outputs not idle after reset");
	a_key_ready: assert property (@(posedge clk) disable iff (rst) rsa_ready_o == (kt < 3))
		else report_mismatch("rsa_ready_o does not match key words taken");
	a_verdict: assert property (@(posedge clk) disable iff (rst) judging |=>
		(verdict_ok ? $rose(led_pass_o) : ($rose(led_fail_o) && !led_pass_o)))
		else report_mismatch("verdict LED wrong one cycle after entry end");
	a_gate: assert property (@(posedge clk) disable iff (rst) aes_ready_o |-> led_pass_o)
		else report_mismatch("aes_ready_o high without a passed check");
	a_open: assert property (@(posedge clk) disable iff (rst) $rose(led_pass_o) |-> aes_ready_o)
		else report_mismatch("aes_ready_o did not follow led_pass_o");
	a_full: assert property (@(posedge clk) disable iff (rst) dut.full |-> !aes_ready_o)
		else report_mismatch("aes_ready_o high with FIFO full");
	a_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid_o && !(out_ready_i && !stall_i) |=> out_valid_o && $stable(out_data_o))
		else report_mismatch("held output changed before acceptance");
	a_freeze: assert property (@(posedge clk) disable iff (rst)
		stall_i |=> $stable(out_valid_o) && (!out_valid_o || $stable(out_data_o)))
		else report_mismatch("output moved during stall");
	a_no_move: assert property (@(posedge clk) disable iff (rst) stall_i |-> !dut.push && !dut.pop)
		else report_mismatch("FIFO push or pop during stall");

	initial begin
		int t;
		stall_i = 1'b0;
		rsa_valid_i = 1'b0;
		ps2_valid_i = 1'b0;
		ps2_done_i = 1'b0;
		ps2_reset_i = 1'b0;
		aes_valid_i = 1'b0;
		out_ready_i = 1'b1;
		rsa_data_i = '0;
		aes_data_i = '0;
		ps2_data_i = '0;
		apply_reset();
		load_key({tag_of(pw_good, 4), 16'h0a5c}, 32'hc3a5_0011, 32'hffff_fffb);
		type_entry(pw_good, 2, 1'b0); // prefix of the good phrase
		type_byte(8'h00, 1'b0, 1'b1); // clear it
		type_entry(pw_bad, 2, 1'b1); // only the rest of the phrase
		wait_verdict("wrong passphrase verdict");
		type_entry(pw_good, 4, 1'b1);
		wait_verdict("correct passphrase verdict");
		rnd_on <= 1'b1;
		send_session(12);
		t = 0;
		while (n_out < 12 && t < 5000) begin
			@(negedge clk);
			t++;
		end
		if (n_out < 12)
			time_out("unwrapped results");
		rnd_on <= 1'b0;
		@(negedge clk);
		stall_i = 1'b0;
		out_ready_i = 1'b1;
		a_drained: assert (exp_q.size() == 0)
			else report_mismatch("expected results left in queue");
		// second run, entry closed by the byte limit
		apply_reset();
		load_key({tag_of(pw_long, `PASS_MAX), 16'h0001}, 32'h0001_0001, 32'h7fff_ffff);
		type_entry(pw_long, `PASS_MAX, 1'b0);
		wait_verdict("full length passphrase verdict");
		repeat (3) @(negedge clk);
		a_passed: assert (led_pass_o)
			else report_mismatch("led_pass_o low after full length entry");
		$display("mismatches: %0d  timeouts: %0d", errors, timeouts);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/unwrap_pkg.sv
verilog/cipher_fifo.sv
verilog/key_intake.sv
verilog/modexp_unwrap.sv
verilog/key_unwrap_top.sv
dv/key_unwrap_tb.sv

//--- Makefile
SIM    := verilator
FLAGS  := --binary --assert --timescale 1ns/1ps -Wno-fatal
TOP    := key_unwrap_tb
FLIST  := vlog.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
LOG    := sim.log
SRCS   := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
